//--- all.f
common/cpu_pkg.sv
core/core_regfile.sv
core/mini_core.sv
verilog/ahb_master_port.sv
verilog/cpu_2port.sv
bench/ahb_mem_model.sv
bench/tb_cpu_2port.sv

//--- bench/ahb_mem_model.sv
// AHB-Lite slave memory for the testbench
// Random wait states, optional error response, word loader
`timescale 1ns/1ns

module ahb_mem_model #(
	parameter int DEPTH    = 1024,
	parameter int WAIT_PCT = 30,
	parameter int MAX_WAIT = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cpu_pkg::ahb_m2s_t        ahb_i,
	output cpu_pkg::ahb_s2m_t        ahb_o,
	input  logic                     err_en_i,
	input  logic                     load_en_i,
	input  logic [$clog2(DEPTH)-1:0] load_addr_i,
	input  logic [31:0]              load_data_i
);

	localparam int AW = $clog2(DEPTH);

	logic [31:0] mem [DEPTH];
	logic        dph_q;
	logic        write_q;
	logic        hready_q;
	logic        hresp_q;
	logic [31:0] addr_q;
	int          wait_q;
	int          waits;
	logic        wr_en;

	// ------------------------------
	// Transfer tracking
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_q    <= 1'b0;
			write_q  <= 1'b0;
			addr_q   <= '0;
			hready_q <= 1'b1;
			hresp_q  <= 1'b0;
			wait_q   <= 0;
		end else if (hready_q) begin
			// Data phase done, new address phase may start
			dph_q   <= 1'b0;
			hresp_q <= 1'b0;
			if (ahb_i.htrans == cpu_pkg::HTRANS_NSEQ) begin
				waits = 0;
				if ($urandom_range(99) < WAIT_PCT) begin
					waits = int'($urandom_range(MAX_WAIT, 1));
				end
				dph_q   <= 1'b1;
				addr_q  <= ahb_i.haddr;
				write_q <= ahb_i.hwrite;
				if (err_en_i) begin
					// First cycle of the two-cycle error
					hready_q <= 1'b0;
					hresp_q  <= 1'b1;
				end else begin
					wait_q   <= waits;
					hready_q <= (waits == 0);
				end
			end else if ($urandom_range(99) < WAIT_PCT) begin
				// Idle stall on the shared hready
				// A following address phase has to hold
				wait_q   <= int'($urandom_range(MAX_WAIT, 1));
				hready_q <= 1'b0;
			end
		end else if (hresp_q) begin
			hready_q <= 1'b1;
		end else begin
			wait_q   <= wait_q - 1;
			hready_q <= (wait_q == 1);
		end
	end

	// Write lands on the last data phase cycle
	assign wr_en = dph_q && write_q && hready_q && !hresp_q;

	always @(posedge clk) begin
		if (load_en_i) begin
			mem[load_addr_i] <= load_data_i;
		end else if (wr_en) begin
			mem[addr_q[AW+1:2]] <= ahb_i.hwdata;
		end
	end

	assign ahb_o.hready = hready_q;
	assign ahb_o.hresp  = hresp_q;
	assign ahb_o.hrdata = mem[addr_q[AW+1:2]];

endmodule

//--- bench/tb_cpu_2port.sv
// Testbench for the two-port mini core subsystem
// Random programs against an ISA model, run control and fault cases
`timescale 1ns/1ns

module tb_cpu_2port;

	localparam int NUM_TESTS  = 8;
	localparam int NUM_INSTR  = 24;
	localparam int MAX_INSTR  = 32;
	localparam int MAX_WAIT   = 3;
	localparam int LOAD_WORDS = 256;
	localparam int WATCHDOG_NS = NUM_TESTS * (MAX_INSTR * (2 + MAX_WAIT) * 2 * 4
		+ LOAD_WORDS * 4 + 400) + 4000;

	logic              clk;
	logic              rst_n;
	logic              halt_req;
	logic              halt_on_reset;
	logic              resume;
	logic              halted;
	logic              running;
	logic              fault;
	cpu_pkg::ahb_m2s_t i_m2s;
	cpu_pkg::ahb_s2m_t i_s2m;
	cpu_pkg::ahb_m2s_t d_m2s;
	cpu_pkg::ahb_s2m_t d_s2m;
	logic              d_err_en;
	logic              i_load_en;
	logic              d_load_en;
	logic [9:0]        load_addr;
	logic [31:0]       i_load_data;
	logic [31:0]       d_load_data;

	// Program image and model state
	logic [31:0] prog [64];
	logic [31:0] mregs [8];
	logic [31:0] mdm [LOAD_WORDS];
	logic [31:0] exp_fetch [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];

	// Observed bus activity, filled by the monitor only
	logic [31:0] fetch_seen [$];
	logic [31:0] st_addr_seen [$];
	logic [31:0] st_data_seen [$];
	logic        d_pend;
	logic [31:0] d_pend_addr;
	logic        i_stall;
	logic        d_stall;
	logic [31:0] i_stall_addr;
	logic [31:0] d_stall_addr;
	int          proto_errors = 0;
	int          errors = 0;

	string test_name [NUM_TESTS] = '{"exec_a", "exec_b", "exec_c", "halt_req",
		"halt_on_reset", "bus_error", "illegal_op", "exec_d"};
	int    test_mode [NUM_TESTS] = '{0, 0, 0, 1, 2, 3, 4, 0};

	cpu_2port #(
		.RESET_PC (32'h0)
	) cpu_2port_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_ahb_o         (i_m2s),
		.i_ahb_i         (i_s2m),
		.d_ahb_o         (d_m2s),
		.d_ahb_i         (d_s2m),
		.halt_req_i      (halt_req),
		.halt_on_reset_i (halt_on_reset),
		.resume_i        (resume),
		.halted_o        (halted),
		.running_o       (running),
		.fault_o         (fault)
	);

	ahb_mem_model #(.MAX_WAIT (MAX_WAIT)) imem (
		.clk         (clk),
		.rst_n       (rst_n),
		.ahb_i       (i_m2s),
		.ahb_o       (i_s2m),
		.err_en_i    (1'b0),
		.load_en_i   (i_load_en),
		.load_addr_i (load_addr),
		.load_data_i (i_load_data)
	);

	ahb_mem_model #(.MAX_WAIT (MAX_WAIT)) dmem (
		.clk         (clk),
		.rst_n       (rst_n),
		.ahb_i       (d_m2s),
		.ahb_o       (d_s2m),
		.err_en_i    (d_err_en),
		.load_en_i   (d_load_en),
		.load_addr_i (load_addr),
		.load_data_i (d_load_data)
	);

	// 4 ns clock
	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------
	// Bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			d_pend  = 1'b0;
			i_stall = 1'b0;
			d_stall = 1'b0;
		end else begin
			assert (i_m2s.htrans == cpu_pkg::HTRANS_IDLE || i_m2s.htrans == cpu_pkg::HTRANS_NSEQ)
			else begin
				proto_errors++;
				$display("Instruction port drove a reserved htrans value");
			end
			assert (d_m2s.htrans == cpu_pkg::HTRANS_IDLE || d_m2s.htrans == cpu_pkg::HTRANS_NSEQ)
			else begin
				proto_errors++;
				$display("Data port drove a reserved htrans value");
			end
			assert (!i_m2s.hwrite) else begin
				proto_errors++;
				$display("Instruction port drove hwrite high");
			end
			if (i_stall) begin
				assert (i_m2s.htrans == cpu_pkg::HTRANS_NSEQ && i_m2s.haddr == i_stall_addr)
				else begin
					proto_errors++;
					$display("Instruction port address changed during a wait state");
				end
			end
			if (d_stall) begin
				assert (d_m2s.htrans == cpu_pkg::HTRANS_NSEQ && d_m2s.haddr == d_stall_addr)
				else begin
					proto_errors++;
					$display("Data port address changed during a wait state");
				end
			end
			// Write data phase ends before the next address phase opens
			if (d_pend && d_s2m.hready) begin
				st_addr_seen.push_back(d_pend_addr);
				st_data_seen.push_back(d_m2s.hwdata);
				d_pend = 1'b0;
			end
			if (i_m2s.htrans == cpu_pkg::HTRANS_NSEQ && i_s2m.hready) begin
				fetch_seen.push_back(i_m2s.haddr);
			end
			if (d_m2s.htrans == cpu_pkg::HTRANS_NSEQ && d_s2m.hready) begin
				d_pend      = d_m2s.hwrite;
				d_pend_addr = d_m2s.haddr;
			end
			i_stall      = (i_m2s.htrans == cpu_pkg::HTRANS_NSEQ) && !i_s2m.hready;
			i_stall_addr = i_m2s.haddr;
			d_stall      = (d_m2s.htrans == cpu_pkg::HTRANS_NSEQ) && !d_s2m.hready;
			d_stall_addr = d_m2s.haddr;
		end
	end

	// ------------------------------
	// Helpers
	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act) else begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic step_n(input int n);
		for (int i = 0; i < n; i++) begin
			step();
		end
	endtask

	task automatic wait_halted();
		do step(); while (halted !== 1'b1);
	endtask

	task automatic pulse_resume();
		resume = 1'b1;
		step();
		resume = 1'b0;
	endtask

	// Word encoding by field positions
	function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
			input logic [2:0] rs, input logic [15:0] imm);
		return {op, 1'b0, rd, 1'b0, rs, 4'h0, imm};
	endfunction

	// Data memory fill, depends on the full word index
	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	// ------------------------------
	// Program generator
	task automatic make_program(input int mode);
		int          pick;
		int          off;
		int          v;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [15:0] imm;
		for (int i = 0; i < NUM_INSTR; i++) begin
			pick = int'($urandom_range(4));
			rd   = 3'($urandom_range(7));
			rs   = 3'($urandom_range(7));
			v    = int'($urandom_range(255)) - 128;
			imm  = v[15:0];
			// Loads and stores use r0 as base, so addresses stay in range
			case (pick)
				0: prog[i] = encode(cpu_pkg::OP_ADDI, rd, rs, imm);
				2: prog[i] = encode(cpu_pkg::OP_LW, rd, 3'd0, 16'(int'($urandom_range(63)) * 4));
				3: prog[i] = encode(cpu_pkg::OP_SW, rd, 3'd0, 16'(int'($urandom_range(63)) * 4));
				4: begin
					// Forward only, never past the final HALT
					off = int'($urandom_range(3, 1));
					if (i + off > NUM_INSTR) begin
						off = NUM_INSTR - i;
					end
					if (i < 4) begin
						prog[i] = encode(cpu_pkg::OP_ADD, rd, rs, 16'h0);
					end else begin
						prog[i] = encode(cpu_pkg::OP_BNE, rd, rs, 16'(off));
					end
				end
				default: prog[i] = encode(cpu_pkg::OP_ADD, rd, rs, 16'h0);
			endcase
		end
		for (int i = NUM_INSTR; i < 64; i++) begin
			prog[i] = encode(cpu_pkg::OP_HALT, 3'd0, 3'd0, 16'h0);
		end
		if (mode == 3) begin
			prog[1] = encode(cpu_pkg::OP_SW, 3'd1, 3'd0, 16'h0010);
		end
		if (mode == 4) begin
			prog[2] = 32'hf000_0000;
		end
	endtask

	// ------------------------------
	// ISA reference model
	task automatic run_model();
		int          idx;
		int          count;
		logic [31:0] ins;
		logic [31:0] sext;
		logic [31:0] addr;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic        done;
		exp_fetch.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		for (int i = 0; i < 8; i++) begin
			mregs[i] = '0;
		end
		for (int i = 0; i < LOAD_WORDS; i++) begin
			mdm[i] = fill_word(i);
		end
		idx   = 0;
		count = 0;
		done  = 1'b0;
		while (!done && count < 200) begin
			exp_fetch.push_back(32'(idx * 4));
			ins  = prog[idx];
			rd   = ins[26:24];
			rs   = ins[22:20];
			sext = {{16{ins[15]}}, ins[15:0]};
			addr = mregs[rs] + sext;
			count++;
			case (ins[31:28])
				cpu_pkg::OP_ADDI: begin
					if (rd != 3'd0) mregs[rd] = mregs[rs] + sext;
					idx++;
				end
				cpu_pkg::OP_ADD: begin
					if (rd != 3'd0) mregs[rd] = mregs[rd] + mregs[rs];
					idx++;
				end
				cpu_pkg::OP_LW: begin
					if (rd != 3'd0) mregs[rd] = mdm[addr[9:2]];
					idx++;
				end
				cpu_pkg::OP_SW: begin
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(mregs[rd]);
					mdm[addr[9:2]] = mregs[rd];
					idx++;
				end
				cpu_pkg::OP_BNE: begin
					idx = idx + ((mregs[rd] != mregs[rs]) ? int'(ins[15:0]) : 1);
				end
				default: done = 1'b1;
			endcase
		end
	endtask

	// ------------------------------
	// Memory load and reset
	task automatic load_memories();
		for (int i = 0; i < LOAD_WORDS; i++) begin
			load_addr   = 10'(i);
			i_load_en   = (i < 64);
			i_load_data = prog[i % 64];
			d_load_en   = 1'b1;
			d_load_data = fill_word(i);
			step();
		end
		i_load_en = 1'b0;
		d_load_en = 1'b0;
	endtask

	task automatic apply_reset(input string name, input logic hold_halt);
		halt_on_reset = hold_halt;
		rst_n         = 1'b0;
		for (int i = 0; i < 4; i++) begin
			step();
			check_value({name, "/rst_i_htrans"}, 32'(cpu_pkg::HTRANS_IDLE), 32'(i_m2s.htrans));
			check_value({name, "/rst_d_htrans"}, 32'(cpu_pkg::HTRANS_IDLE), 32'(d_m2s.htrans));
			check_value({name, "/rst_halted"}, 32'd0, 32'(halted));
			check_value({name, "/rst_running"}, 32'd0, 32'(running));
			check_value({name, "/rst_fault"}, 32'd0, 32'(fault));
		end
		rst_n = 1'b1;
		// First cycle out of reset still idle
		check_value({name, "/post_rst_i_htrans"}, 32'(cpu_pkg::HTRANS_IDLE), 32'(i_m2s.htrans));
		check_value({name, "/post_rst_halted"}, 32'd0, 32'(halted));
	endtask

	// ------------------------------
	// Result comparison from the queue offsets of this test
	task automatic compare_results(input string name, input int f_base, input int s_base);
		check_value({name, "/halted"}, 32'd1, 32'(halted));
		check_value({name, "/running"}, 32'd0, 32'(running));
		check_value({name, "/fault"}, 32'd0, 32'(fault));
		check_value({name, "/fetch_count"}, exp_fetch.size(), fetch_seen.size() - f_base);
		for (int i = 0; i < exp_fetch.size() && f_base + i < fetch_seen.size(); i++) begin
			check_value({name, "/fetch_addr"}, exp_fetch[i], fetch_seen[f_base + i]);
		end
		check_value({name, "/store_count"}, exp_st_addr.size(), st_addr_seen.size() - s_base);
		for (int i = 0; i < exp_st_addr.size() && s_base + i < st_addr_seen.size(); i++) begin
			check_value({name, "/store_addr"}, exp_st_addr[i], st_addr_seen[s_base + i]);
			check_value({name, "/store_data"}, exp_st_data[i], st_data_seen[s_base + i]);
		end
	endtask

	// Faulted core stays parked and ignores resume
	task automatic check_fault_stop(input string name);
		int n;
		wait_halted();
		check_value({name, "/fault"}, 32'd1, 32'(fault));
		n = fetch_seen.size();
		step_n(10);
		pulse_resume();
		step_n(10);
		check_value({name, "/fetch_after_fault"}, 32'(n), 32'(fetch_seen.size()));
		check_value({name, "/halted"}, 32'd1, 32'(halted));
		check_value({name, "/running"}, 32'd0, 32'(running));
		check_value({name, "/fault_sticky"}, 32'd1, 32'(fault));
	endtask

	task automatic run_test(input string name, input int mode);
		int f_base;
		int s_base;
		int n;
		make_program(mode);
		run_model();
		load_memories();
		d_err_en = (mode == 3);
		f_base   = fetch_seen.size();
		s_base   = st_addr_seen.size();
		apply_reset(name, mode == 2);
		case (mode)
			1: begin
				step_n(int'($urandom_range(20, 6)));
				halt_req = 1'b1;
				wait_halted();
				n = fetch_seen.size();
				step_n(10);
				check_value({name, "/fetch_while_halted"}, 32'(n), 32'(fetch_seen.size()));
				halt_req = 1'b0;
				pulse_resume();
				check_value({name, "/running_after_resume"}, 32'd1, 32'(running));
				wait_halted();
				compare_results(name, f_base, s_base);
			end
			2: begin
				step_n(2);
				check_value({name, "/halted_at_boot"}, 32'd1, 32'(halted));
				check_value({name, "/running_at_boot"}, 32'd0, 32'(running));
				step_n(10);
				check_value({name, "/fetch_at_boot"}, 32'(f_base), 32'(fetch_seen.size()));
				halt_on_reset = 1'b0;
				pulse_resume();
				check_value({name, "/running_after_resume"}, 32'd1, 32'(running));
				wait_halted();
				compare_results(name, f_base, s_base);
			end
			3, 4: check_fault_stop(name);
			default: begin
				wait_halted();
				compare_results(name, f_base, s_base);
			end
		endcase
		d_err_en = 1'b0;
	endtask

	// ------------------------------
	// Main sequence
	initial begin
		void'($urandom(32'h5c64d0d4));
		rst_n         = 1'b0;
		halt_req      = 1'b0;
		halt_on_reset = 1'b1;
		resume        = 1'b0;
		d_err_en      = 1'b0;
		i_load_en     = 1'b0;
		d_load_en     = 1'b0;
		load_addr     = '0;
		i_load_data   = '0;
		d_load_data   = '0;
		// Park the core before the first load
		step_n(4);
		rst_n = 1'b1;
		step_n(4);
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(test_name[t], test_mode[t]);
		end
		$display("Errors: %0d (checks %0d, protocol %0d)", errors + proto_errors,
			errors, proto_errors);
		if (errors + proto_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the DUT stopped making progress");
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- common/cpu_pkg.sv
// Shared definitions for the two-port mini core subsystem
// Widths, opcodes, AHB transfer codes and the bus structs
package cpu_pkg;

	// ------------------------------
	// Widths
	localparam int W_DATA = 32;
	localparam int W_ADDR = 32;

	// ------------------------------
	// Instruction word
	//   [31:28] opcode
	//   [26:24] rd
	//   [22:20] rs
	//   [15:0]  signed immediate
	// ADDI  rd = rs + imm
	// ADD   rd = rd + rs
	// LW    rd = mem[rs + imm]
	// SW    mem[rs + imm] = rd
	// BNE   pc = pc + imm * 4 when rd != rs
	// HALT  stop, resume continues at pc + 4
	typedef enum logic [3:0] {
		OP_ADDI = 4'h1,
		OP_ADD  = 4'h2,
		OP_LW   = 4'h3,
		OP_SW   = 4'h4,
		OP_BNE  = 4'h5,
		OP_HALT = 4'h6
	} opcode_t;

	// AHB-Lite transfer type, only single transfers
	typedef enum logic [1:0] {
		HTRANS_IDLE = 2'b00,
		HTRANS_NSEQ = 2'b10
	} htrans_t;

	// ------------------------------
	// Core side of one bus channel
	typedef struct packed {
		logic              req;
		logic [W_ADDR-1:0] addr;
		logic              write;
		logic [W_DATA-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic              aph_ready;
		logic              dph_ready;
		logic              dph_err;
		logic [W_DATA-1:0] rdata;
	} bus_rsp_t;

	// AHB-Lite master outputs and slave responses
	typedef struct packed {
		logic [W_ADDR-1:0] haddr;
		htrans_t           htrans;
		logic              hwrite;
		logic [2:0]        hsize;
		logic [2:0]        hburst;
		logic [3:0]        hprot;
		logic              hmastlock;
		logic [W_DATA-1:0] hwdata;
	} ahb_m2s_t;

	typedef struct packed {
		logic              hready;
		logic              hresp;
		logic [W_DATA-1:0] hrdata;
	} ahb_s2m_t;

endpackage

//--- core/core_regfile.sv
// Mini core register file
// Eight words, two read ports, one write port, r0 reads zero
`timescale 1ns/1ns

module core_regfile (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [2:0]                 ra_i,
	input  logic [2:0]                 rb_i,
	output logic [cpu_pkg::W_DATA-1:0] ra_data_o,
	output logic [cpu_pkg::W_DATA-1:0] rb_data_o,
	input  logic                       we_i,
	input  logic [2:0]                 wa_i,
	input  logic [cpu_pkg::W_DATA-1:0] wd_i
);

	logic [cpu_pkg::W_DATA-1:0] regs_q [8];

	// Single write port, writes to r0 dropped so it stays zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (wa_i != 3'd0)) begin
			regs_q[wa_i] <= wd_i;
		end
	end

	// Asynchronous reads
	// New value visible the cycle after the write
	assign ra_data_o = regs_q[ra_i];
	assign rb_data_o = regs_q[rb_i];

endmodule

//--- core/mini_core.sv
// Mini accumulator-register core
// Fetch/execute FSM with run control, separate fetch and load/store channels
`timescale 1ns/1ns

module mini_core #(
	parameter logic [cpu_pkg::W_ADDR-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	// Fetch channel
	output cpu_pkg::bus_req_t ibus_o,
	input  cpu_pkg::bus_rsp_t ibus_i,
	// Load/store channel
	output cpu_pkg::bus_req_t dbus_o,
	input  cpu_pkg::bus_rsp_t dbus_i,
	// Run control
	input  logic              halt_req_i,
	input  logic              halt_on_reset_i,
	input  logic              resume_i,
	output logic              halted_o,
	output logic              running_o,
	output logic              fault_o
);

	localparam logic [cpu_pkg::W_ADDR-1:0] PC_STEP = 4;

	typedef enum logic [2:0] {
		FETCH_A,
		FETCH_D,
		EXEC,
		MEM_A,
		MEM_D,
		HALTED
	} state_t;

	state_t state_q;
	state_t state_d;

	logic [cpu_pkg::W_ADDR-1:0] pc_q;
	logic [cpu_pkg::W_ADDR-1:0] pc_d;
	logic [cpu_pkg::W_DATA-1:0] instr_q;
	logic                       boot_done_q;
	logic                       fault_q;
	logic                       fault_d;

	// Decode
	cpu_pkg::opcode_t           opcode;
	logic [2:0]                 rd;
	logic [2:0]                 rs;
	logic [cpu_pkg::W_DATA-1:0] imm_sext;

	// Datapath
	logic [cpu_pkg::W_DATA-1:0] rd_data;
	logic [cpu_pkg::W_DATA-1:0] rs_data;
	logic [cpu_pkg::W_DATA-1:0] alu_a;
	logic [cpu_pkg::W_DATA-1:0] alu_b;
	logic [cpu_pkg::W_DATA-1:0] alu_sum;
	logic [cpu_pkg::W_ADDR-1:0] pc_plus4;
	logic [cpu_pkg::W_ADDR-1:0] br_target;
	logic                       rf_we;
	logic [cpu_pkg::W_DATA-1:0] rf_wd;
	state_t                     boundary_state;

	// ------------------------------
	// Decode and ALU
	assign opcode   = cpu_pkg::opcode_t'(instr_q[31:28]);
	assign rd       = instr_q[26:24];
	assign rs       = instr_q[22:20];
	assign imm_sext = {{(cpu_pkg::W_DATA-16){instr_q[15]}}, instr_q[15:0]};

	// ADD accumulates into rd, everything else is rs + imm
	// Same adder gives the LW/SW address
	assign alu_a   = (opcode == cpu_pkg::OP_ADD) ? rd_data : rs_data;
	assign alu_b   = (opcode == cpu_pkg::OP_ADD) ? rs_data : imm_sext;
	assign alu_sum = alu_a + alu_b;

	assign pc_plus4  = pc_q + PC_STEP;
	// Branch offset counted in words from the BNE itself
	assign br_target = pc_q + {imm_sext[cpu_pkg::W_ADDR-3:0], 2'b00};

	// Load data or ALU result
	assign rf_wd = (state_q == MEM_D) ? dbus_i.rdata : alu_sum;

	core_regfile regfile_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ra_i      (rd),
		.rb_i      (rs),
		.ra_data_o (rd_data),
		.rb_data_o (rs_data),
		.we_i      (rf_we),
		.wa_i      (rd),
		.wd_i      (rf_wd)
	);

	// ------------------------------
	// Bus requests
	// Fetch side is read only
	always_comb begin
		ibus_o.req   = (state_q == FETCH_A);
		ibus_o.addr  = pc_q;
		ibus_o.write = 1'b0;
		ibus_o.wdata = '0;
	end

	// Regs and instr stay put through MEM_A and MEM_D
	// so addr and wdata hold without extra flops
	always_comb begin
		dbus_o.req   = (state_q == MEM_A);
		dbus_o.addr  = alu_sum;
		dbus_o.write = (opcode == cpu_pkg::OP_SW);
		dbus_o.wdata = rd_data;
	end

	// ------------------------------
	// FSM
	// Instruction boundary, halt request checked here only
	assign boundary_state = halt_req_i ? HALTED : FETCH_A;

	always_comb begin
		state_d = state_q;
		pc_d    = pc_q;
		fault_d = fault_q;
		rf_we   = 1'b0;
		unique case (state_q)
			HALTED: begin
				// First cycle out of reset decides halt-on-reset
				if (!boot_done_q) begin
					if (!halt_on_reset_i) begin
						state_d = FETCH_A;
					end
				end else if (resume_i && !halt_req_i && !fault_q) begin
					state_d = FETCH_A;
				end
			end
			FETCH_A: begin
				if (ibus_i.aph_ready) begin
					state_d = FETCH_D;
				end
			end
			FETCH_D: begin
				if (ibus_i.dph_ready) begin
					if (ibus_i.dph_err) begin
						fault_d = 1'b1;
						state_d = HALTED;
					end else begin
						state_d = EXEC;
					end
				end
			end
			EXEC: begin
				case (opcode)
					cpu_pkg::OP_ADDI, cpu_pkg::OP_ADD: begin
						rf_we   = 1'b1;
						pc_d    = pc_plus4;
						state_d = boundary_state;
					end
					cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
						state_d = MEM_A;
					end
					cpu_pkg::OP_BNE: begin
						pc_d    = (rd_data != rs_data) ? br_target : pc_plus4;
						state_d = boundary_state;
					end
					cpu_pkg::OP_HALT: begin
						pc_d    = pc_plus4;
						state_d = HALTED;
					end
					default: begin
						// Illegal opcode, pc left on the bad word
						fault_d = 1'b1;
						state_d = HALTED;
					end
				endcase
			end
			MEM_A: begin
				if (dbus_i.aph_ready) begin
					state_d = MEM_D;
				end
			end
			MEM_D: begin
				if (dbus_i.dph_ready) begin
					if (dbus_i.dph_err) begin
						fault_d = 1'b1;
						state_d = HALTED;
					end else begin
						rf_we   = (opcode == cpu_pkg::OP_LW);
						pc_d    = pc_plus4;
						state_d = boundary_state;
					end
				end
			end
			default: begin
				state_d = HALTED;
			end
		endcase
	end

	// Reset parks in HALTED with boot_done low, bus stays idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= HALTED;
			pc_q        <= RESET_PC;
			fault_q     <= 1'b0;
			boot_done_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			pc_q        <= pc_d;
			fault_q     <= fault_d;
			boot_done_q <= 1'b1;
		end
	end

	// Instruction capture at end of fetch data phase
	always_ff @(posedge clk) begin
		if ((state_q == FETCH_D) && ibus_i.dph_ready) begin
			instr_q <= ibus_i.rdata;
		end
	end

	// Status
	assign halted_o  = (state_q == HALTED) && boot_done_q;
	assign running_o = (state_q != HALTED);
	assign fault_o   = fault_q;

	// ------------------------------
	// Checks
	// One channel active at a time
	a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
		!(ibus_o.req && dbus_o.req));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_cpu_2port \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Test OK" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation did not pass"
	exit 1
fi

//--- verilog/ahb_master_port.sv
// AHB-Lite master adapter for one core bus channel
// Single outstanding transfer, data phase tracked by one flag
`timescale 1ns/1ns

module ahb_master_port #(
	parameter bit FETCH_ONLY = 1'b0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::bus_req_t core_req_i,
	output cpu_pkg::bus_rsp_t core_rsp_o,
	output cpu_pkg::ahb_m2s_t ahb_o,
	input  cpu_pkg::ahb_s2m_t ahb_i
);

	// Fixed transfer attributes
	localparam logic [2:0] HSIZE_WORD    = 3'b010;
	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	localparam logic [3:0] HPROT_DATA    = 4'b0011;

	logic dph_active_q;

	// ------------------------------
	// Data phase flag
	// Address phase accepted on hready, so the flag follows req then
	// Holds through wait states
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active_q <= 1'b0;
		end else if (ahb_i.hready) begin
			dph_active_q <= core_req_i.req;
		end
	end

	// ------------------------------
	// Master outputs
	// Core holds addr and control while req waits, so no local flops
	always_comb begin
		ahb_o.haddr     = core_req_i.addr;
		ahb_o.htrans    = core_req_i.req ? cpu_pkg::HTRANS_NSEQ : cpu_pkg::HTRANS_IDLE;
		ahb_o.hwrite    = FETCH_ONLY ? 1'b0 : core_req_i.write;
		ahb_o.hsize     = HSIZE_WORD;
		ahb_o.hburst    = HBURST_SINGLE;
		ahb_o.hprot     = HPROT_DATA;
		ahb_o.hmastlock = 1'b0;
		// Write data driven in the data phase, core keeps it until dph_ready
		ahb_o.hwdata    = FETCH_ONLY ? '0 : core_req_i.wdata;
	end

	// Core-side handshake
	always_comb begin
		core_rsp_o.aph_ready = ahb_i.hready && core_req_i.req;
		core_rsp_o.dph_ready = ahb_i.hready && dph_active_q;
		core_rsp_o.dph_err   = ahb_i.hready && dph_active_q && ahb_i.hresp;
		core_rsp_o.rdata     = ahb_i.hrdata;
	end

	// ------------------------------
	// Checks
	// Stalled address phase holds
	a_aph_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ahb_o.htrans == cpu_pkg::HTRANS_NSEQ && !ahb_i.hready) |=>
		(ahb_o.htrans == cpu_pkg::HTRANS_NSEQ && $stable(ahb_o.haddr)));

	// No data phase response without a tracked transfer
	a_dph_flag: assert property (@(posedge clk) disable iff (!rst_n)
		core_rsp_o.dph_ready |-> dph_active_q);

endmodule

//--- verilog/cpu_2port.sv
// Two-port mini core subsystem
// Core with separate AHB-Lite masters for fetch and load/store
`timescale 1ns/1ns

module cpu_2port #(
	parameter logic [cpu_pkg::W_ADDR-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	// Instruction fetch port
	output cpu_pkg::ahb_m2s_t i_ahb_o,
	input  cpu_pkg::ahb_s2m_t i_ahb_i,
	// Load/store port
	output cpu_pkg::ahb_m2s_t d_ahb_o,
	input  cpu_pkg::ahb_s2m_t d_ahb_i,
	// Run control
	input  logic              halt_req_i,
	input  logic              halt_on_reset_i,
	input  logic              resume_i,
	output logic              halted_o,
	output logic              running_o,
	output logic              fault_o
);

	// Core-side channels
	cpu_pkg::bus_req_t ibus_req;
	cpu_pkg::bus_rsp_t ibus_rsp;
	cpu_pkg::bus_req_t dbus_req;
	cpu_pkg::bus_rsp_t dbus_rsp;

	// ------------------------------
	// Core
	mini_core #(
		.RESET_PC (RESET_PC)
	) core_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.ibus_o          (ibus_req),
		.ibus_i          (ibus_rsp),
		.dbus_o          (dbus_req),
		.dbus_i          (dbus_rsp),
		.halt_req_i      (halt_req_i),
		.halt_on_reset_i (halt_on_reset_i),
		.resume_i        (resume_i),
		.halted_o        (halted_o),
		.running_o       (running_o),
		.fault_o         (fault_o)
	);

	// ------------------------------
	// Fetch port, read only
	ahb_master_port #(
		.FETCH_ONLY (1'b1)
	) i_port_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_req_i (ibus_req),
		.core_rsp_o (ibus_rsp),
		.ahb_o      (i_ahb_o),
		.ahb_i      (i_ahb_i)
	);

	// Load/store port
	ahb_master_port #(
		.FETCH_ONLY (1'b0)
	) d_port_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_req_i (dbus_req),
		.core_rsp_o (dbus_rsp),
		.ahb_o      (d_ahb_o),
		.ahb_i      (d_ahb_i)
	);

endmodule
